/* renderPkg.sv */
package renderPkg;

	// ----------------------------------------------------------
	// Coordinates
	// ----------------------------------------------------------

	// Screen coordinate as sent by the host, -2048..+2047
	typedef logic signed [11:0] coord_t;

	// Draw area bound, also any pixel position inside video memory
	typedef logic [9:0] areaCoord_t;

	// ----------------------------------------------------------
	// Pixels and video memory blocks
	// ----------------------------------------------------------

	// 15 bit colour, bit 15 is the mask bit
	typedef logic [15:0] colour_t;

	// One memory block holds 16 horizontal pixels (32 bytes)
	localparam int BLOCK_PIXELS = 16;

	// Row low 9 bits followed by pixel x bits 9..4
	typedef logic [14:0] blockAdr_t;

	// Pixel 0 in the lowest 16 bits
	typedef logic [BLOCK_PIXELS*16-1:0] blockData_t;

	// One bit per pixel, set where written
	typedef logic [BLOCK_PIXELS-1:0] blockMask_t;

	// Fill sequencing
	typedef enum logic [2:0] {
		IDLE	= 3'd0,
		CLIP	= 3'd1,
		SCAN	= 3'd2,
		FLUSH	= 3'd3,
		DRAIN	= 3'd4
	} scanState_t;

endpackage

/* rectClip.sv */
module rectClip (
	input  logic					i_clk,
	input  logic					i_load,
	input  renderPkg::coord_t		i_rectX,
	input  renderPkg::coord_t		i_rectY,
	input  logic [10:0]				i_rectW,
	input  logic [10:0]				i_rectH,
	input  renderPkg::areaCoord_t	i_areaX0,
	input  renderPkg::areaCoord_t	i_areaY0,
	input  renderPkg::areaCoord_t	i_areaX1,
	input  renderPkg::areaCoord_t	i_areaY1,
	output renderPkg::areaCoord_t	o_clipX0,
	output renderPkg::areaCoord_t	o_clipY0,
	output renderPkg::areaCoord_t	o_clipX1,
	output renderPkg::areaCoord_t	o_clipY1,
	output logic					o_reject
);

	// 14 bit signed is wide enough for origin + size - 1
	logic signed [13:0] rectL, rectT, rectR, rectB;
	logic signed [13:0] areaL, areaT, areaR, areaB;
	logic signed [13:0] cutL, cutT, cutR, cutB;
	logic emptySize;

	// Inclusive rectangle edges
	assign rectL = i_rectX;
	assign rectT = i_rectY;
	assign rectR = rectL + $signed({3'b000, i_rectW}) - 14'sd1;
	assign rectB = rectT + $signed({3'b000, i_rectH}) - 14'sd1;

	// Draw area is always positive
	assign areaL = $signed({4'b0000, i_areaX0});
	assign areaT = $signed({4'b0000, i_areaY0});
	assign areaR = $signed({4'b0000, i_areaX1});
	assign areaB = $signed({4'b0000, i_areaY1});

	// Intersection
	assign cutL = (rectL > areaL) ? rectL : areaL;
	assign cutT = (rectT > areaT) ? rectT : areaT;
	assign cutR = (rectR < areaR) ? rectR : areaR;
	assign cutB = (rectB < areaB) ? rectB : areaB;

	assign emptySize = (i_rectW == 11'd0) | (i_rectH == 11'd0);

	// Loaded with the start strobe, valid in CLIP
	always_ff @(posedge i_clk) begin
		if (i_load) begin
			o_clipX0 <= cutL[9:0];
			o_clipY0 <= cutT[9:0];
			o_clipX1 <= cutR[9:0];
			o_clipY1 <= cutB[9:0];
			// Nothing left once clipped, or disjoint from area
			o_reject <= emptySize | (cutL > cutR) | (cutT > cutB);
		end
	end

endmodule

/* rectScanner.sv */
module rectScanner (
	input  logic					i_clk,
	input  logic					i_nrst,
	input  logic					i_start,
	input  renderPkg::areaCoord_t	i_clipX0,
	input  renderPkg::areaCoord_t	i_clipY0,
	input  renderPkg::areaCoord_t	i_clipX1,
	input  renderPkg::areaCoord_t	i_clipY1,
	input  logic					i_reject,
	input  logic					i_stall,
	input  logic					i_writerIdle,
	output logic					o_loadClip,
	output renderPkg::areaCoord_t	o_pixX,
	output renderPkg::areaCoord_t	o_pixY,
	output logic					o_writeL,
	output logic					o_writeR,
	output logic					o_flush,
	output logic					o_busy,
	output logic					o_done
);

	renderPkg::scanState_t state, nextState;
	renderPkg::areaCoord_t leftX, nextX, nextY;
	logic [10:0] stepX;
	logic lastInRow, lastRow, newPair;
	logic nextWriteL, nextWriteR, nextFlush, setDone;

	// Pairs are even aligned, first one may start on the odd pixel
	assign leftX = {i_clipX0[9:1], 1'b0};
	// 11 bits so that the last pair of column 1022 does not wrap
	assign stepX = {1'b0, o_pixX} + 11'd2;
	assign lastInRow = (stepX > {1'b0, i_clipX1});
	assign lastRow = (o_pixY == i_clipY1);

	// ----------------------------------------------------------
	// Next state and next pair
	// ----------------------------------------------------------
	always_comb begin
		nextState = state;
		nextX = o_pixX;
		nextY = o_pixY;
		nextWriteL = o_writeL;
		nextWriteR = o_writeR;
		nextFlush = o_flush;
		newPair = 1'b0;
		setDone = 1'b0;

		case (state)
		renderPkg::IDLE: begin
			if (i_start)
				nextState = renderPkg::CLIP;
		end
		renderPkg::CLIP: begin
			// Clip result was loaded on the start edge
			if (i_reject) begin
				nextState = renderPkg::IDLE;
				setDone = 1'b1;
			end else begin
				nextState = renderPkg::SCAN;
				nextX = leftX;
				nextY = i_clipY0;
				newPair = 1'b1;
			end
		end
		renderPkg::SCAN: begin
			// Assembler refused the pair, present it again
			if (!i_stall) begin
				if (!lastInRow) begin
					nextX = stepX[9:0];
					newPair = 1'b1;
				end else if (!lastRow) begin
					nextX = leftX;
					nextY = o_pixY + 10'd1;
					newPair = 1'b1;
				end else begin
					nextState = renderPkg::FLUSH;
					nextWriteL = 1'b0;
					nextWriteR = 1'b0;
					nextFlush = 1'b1;
				end
			end
		end
		renderPkg::FLUSH: begin
			// Flush held until the last block got a slot
			if (!i_stall) begin
				nextState = renderPkg::DRAIN;
				nextFlush = 1'b0;
			end
		end
		renderPkg::DRAIN: begin
			// Last command accepted by memory
			if (i_writerIdle) begin
				nextState = renderPkg::IDLE;
				setDone = 1'b1;
			end
		end
		default: begin
			nextState = renderPkg::IDLE;
		end
		endcase

		// Left pixel only out on an odd left edge, right one on an even right edge
		if (newPair) begin
			nextWriteL = (nextX >= i_clipX0);
			nextWriteR = ({nextX[9:1], 1'b1} <= i_clipX1);
		end
	end

	// ----------------------------------------------------------
	// Registers
	// ----------------------------------------------------------
	always_ff @(posedge i_clk) begin
		if (!i_nrst) begin
			state <= renderPkg::IDLE;
			o_writeL <= 1'b0;
			o_writeR <= 1'b0;
			o_flush <= 1'b0;
			o_done <= 1'b0;
		end else begin
			state <= nextState;
			o_writeL <= nextWriteL;
			o_writeR <= nextWriteR;
			o_flush <= nextFlush;
			o_done <= setDone;
		end
	end

	// Position only matters while the strobes are up
	always_ff @(posedge i_clk) begin
		o_pixX <= nextX;
		o_pixY <= nextY;
	end

	// Start only taken while idle
	assign o_loadClip = (state == renderPkg::IDLE) & i_start;
	assign o_busy = (state != renderPkg::IDLE);

endmodule

/* blockAssembler.sv */
module blockAssembler (
	input  logic					i_clk,
	input  logic					i_nrst,
	input  renderPkg::colour_t		i_colour,
	input  renderPkg::areaCoord_t	i_pixX,
	input  renderPkg::areaCoord_t	i_pixY,
	input  logic					i_writeL,
	input  logic					i_writeR,
	input  logic					i_flush,
	input  logic					i_writerReady,
	output logic					o_stall,
	output logic					o_empty,
	output logic					o_blockValid,
	output renderPkg::blockAdr_t	o_blockAdr,
	output renderPkg::blockData_t	o_blockData,
	output renderPkg::blockMask_t	o_blockMask
);

	renderPkg::blockAdr_t pairAdr;
	renderPkg::blockMask_t slotWrite;
	logic newBlock;
	logic anyWrite, differentBlock, handOff, store, freshBlock;

	// ----------------------------------------------------------
	// Block transition detection
	// ----------------------------------------------------------

	// Same layout as the memory address
	assign pairAdr = {i_pixY[8:0], i_pixX[9:4]};
	assign anyWrite = i_writeL | i_writeR;
	assign differentBlock = (pairAdr != o_blockAdr);

	// Open block leaves when a written pair lands elsewhere, or on flush
	assign handOff = !newBlock & ((anyWrite & differentBlock) | i_flush);

	// Writer still busy with the previous block
	assign o_stall = handOff & !i_writerReady;
	assign o_blockValid = handOff & i_writerReady;

	assign store = anyWrite & !o_stall;
	// Pair starts a block from scratch
	assign freshBlock = newBlock | handOff;

	// Pair position inside the block
	always_comb begin
		slotWrite = '0;
		slotWrite[{i_pixX[3:1], 1'b0}] = i_writeL;
		slotWrite[{i_pixX[3:1], 1'b1}] = i_writeR;
	end

	// ----------------------------------------------------------
	// Open block
	// ----------------------------------------------------------
	always_ff @(posedge i_clk) begin
		if (!i_nrst)
			newBlock <= 1'b1;
		else if (i_flush & !o_stall)
			newBlock <= 1'b1;
		else if (store)
			newBlock <= 1'b0;
	end

	// Unmasked slots keep stale data, the mask covers them
	always_ff @(posedge i_clk) begin
		if (store) begin
			o_blockAdr <= pairAdr;
			o_blockMask <= freshBlock ? slotWrite : (o_blockMask | slotWrite);
			for (int i = 0; i < renderPkg::BLOCK_PIXELS; i++) begin
				if (slotWrite[i])
					o_blockData[i*16 +: 16] <= i_colour;
			end
		end
	end

	assign o_empty = newBlock;

endmodule

/* memWriter.sv */
module memWriter (
	input  logic					i_clk,
	input  logic					i_nrst,
	input  logic					i_blockValid,
	input  renderPkg::blockAdr_t	i_blockAdr,
	input  renderPkg::blockData_t	i_blockData,
	input  renderPkg::blockMask_t	i_blockMask,
	output logic					o_ready,
	input  logic					i_busy,
	output logic					o_command,
	output renderPkg::blockAdr_t	o_adr,
	output renderPkg::blockMask_t	o_writeMask,
	output renderPkg::blockData_t	o_dataOut
);

	logic full;

	// ----------------------------------------------------------
	// Holding register state
	// ----------------------------------------------------------

	// Blocks only arrive while empty, so load and accept never overlap
	always_ff @(posedge i_clk) begin
		if (!i_nrst)
			full <= 1'b0;
		else if (i_blockValid)
			full <= 1'b1;
		else if (full & !i_busy)
			// Memory took the write this cycle
			full <= 1'b0;
	end

	// Payload stays put until acceptance
	always_ff @(posedge i_clk) begin
		if (i_blockValid) begin
			o_adr <= i_blockAdr;
			o_writeMask <= i_blockMask;
			o_dataOut <= i_blockData;
		end
	end

	// ----------------------------------------------------------
	// Memory command side
	// ----------------------------------------------------------

	// Write request held until a cycle with busy low
	assign o_command = full;

	// Empty also means the output side has drained
	assign o_ready = !full;

endmodule

/* renderTop.sv */
module renderTop (
	input  logic					i_clk,
	input  logic					i_nrst,
	// Host
	input  logic					i_start,
	input  renderPkg::coord_t		i_rectX,
	input  renderPkg::coord_t		i_rectY,
	input  logic [10:0]				i_rectW,
	input  logic [10:0]				i_rectH,
	input  renderPkg::colour_t		i_colour,
	input  renderPkg::areaCoord_t	i_areaX0,
	input  renderPkg::areaCoord_t	i_areaY0,
	input  renderPkg::areaCoord_t	i_areaX1,
	input  renderPkg::areaCoord_t	i_areaY1,
	output logic					o_busy,
	output logic					o_done,
	// Video memory
	output logic					o_command,
	input  logic					i_busy,
	output renderPkg::blockAdr_t	o_adr,
	output renderPkg::blockMask_t	o_writeMask,
	output renderPkg::blockData_t	o_dataOut
);

	renderPkg::areaCoord_t clipX0, clipY0, clipX1, clipY1;
	renderPkg::areaCoord_t pixX, pixY;
	logic loadClip, reject;
	logic writeL, writeR, flush, stall, asmEmpty;
	logic blockValid, writerReady;
	renderPkg::blockAdr_t blockAdr;
	renderPkg::blockData_t blockData;
	renderPkg::blockMask_t blockMask;

	// ----------------------------------------------------------
	// Front end: clip then scan
	// ----------------------------------------------------------
	rectClip rectClipInst (
		.i_clk		(i_clk),		.i_load		(loadClip),
		.i_rectX	(i_rectX),		.i_rectY	(i_rectY),
		.i_rectW	(i_rectW),		.i_rectH	(i_rectH),
		.i_areaX0	(i_areaX0),		.i_areaY0	(i_areaY0),
		.i_areaX1	(i_areaX1),		.i_areaY1	(i_areaY1),
		.o_clipX0	(clipX0),		.o_clipY0	(clipY0),
		.o_clipX1	(clipX1),		.o_clipY1	(clipY1),
		.o_reject	(reject)
	);

	// Done waits for both the open block and the held command
	rectScanner rectScannerInst (
		.i_clk		(i_clk),		.i_nrst		(i_nrst),
		.i_start	(i_start),
		.i_clipX0	(clipX0),		.i_clipY0	(clipY0),
		.i_clipX1	(clipX1),		.i_clipY1	(clipY1),
		.i_reject	(reject),		.i_stall	(stall),
		.i_writerIdle	(asmEmpty & writerReady),
		.o_loadClip	(loadClip),
		.o_pixX		(pixX),			.o_pixY		(pixY),
		.o_writeL	(writeL),		.o_writeR	(writeR),
		.o_flush	(flush),
		.o_busy		(o_busy),		.o_done		(o_done)
	);

	// ----------------------------------------------------------
	// Back end: block build and memory write
	// ----------------------------------------------------------

	// Colour is taken per pixel, host holds it for the whole fill
	blockAssembler blockAssemblerInst (
		.i_clk		(i_clk),		.i_nrst		(i_nrst),
		.i_colour	(i_colour),
		.i_pixX		(pixX),			.i_pixY		(pixY),
		.i_writeL	(writeL),		.i_writeR	(writeR),
		.i_flush	(flush),		.i_writerReady	(writerReady),
		.o_stall	(stall),		.o_empty	(asmEmpty),
		.o_blockValid	(blockValid),
		.o_blockAdr	(blockAdr),
		.o_blockData	(blockData),
		.o_blockMask	(blockMask)
	);

	memWriter memWriterInst (
		.i_clk		(i_clk),		.i_nrst		(i_nrst),
		.i_blockValid	(blockValid),
		.i_blockAdr	(blockAdr),
		.i_blockData	(blockData),
		.i_blockMask	(blockMask),
		.o_ready	(writerReady),
		.i_busy		(i_busy),		.o_command	(o_command),
		.o_adr		(o_adr),		.o_writeMask	(o_writeMask),
		.o_dataOut	(o_dataOut)
	);

endmodule

/* render_chk.sv */
module renderChk (
	input  logic					i_clk,
	input  logic					i_nrst,
	input  logic					i_busy,
	input  logic					i_command,
	input  logic					i_blockValid,
	input  renderPkg::blockAdr_t	i_blockAdr,
	input  renderPkg::blockMask_t	i_blockMask,
	input  renderPkg::blockData_t	i_blockData,
	input  renderPkg::blockAdr_t	i_adr,
	input  renderPkg::blockMask_t	i_mask,
	input  renderPkg::blockData_t	i_data
);

	timeunit 1ns;
	timeprecision 1ps;

	int assertFails = 0;

	// ----------------------------------------------------------
	// Memory command port
	// ----------------------------------------------------------

	// Refused command stays up with the same payload
	holdCommand: assert property (@(posedge i_clk) disable iff (!i_nrst)
		i_command && i_busy |=> i_command && $stable(i_adr) && $stable(i_mask) &&
		$stable(i_data))
	else begin
		assertFails++;
		$error("memory command changed or dropped before acceptance");
	end

	// Accepted command goes away the next cycle
	dropCommand: assert property (@(posedge i_clk) disable iff (!i_nrst)
		i_command && !i_busy |=> !i_command)
	else begin
		assertFails++;
		$error("memory command still up after acceptance");
	end

	// Handed off block is the next command, unchanged
	loadBlock: assert property (@(posedge i_clk) disable iff (!i_nrst)
		i_blockValid |=> i_command && i_adr == $past(i_blockAdr) &&
		i_mask == $past(i_blockMask) && i_data == $past(i_blockData))
	else begin
		assertFails++;
		$error("handed off block not presented as the next memory command");
	end

endmodule

bind memWriter renderChk renderChkInst (
	.i_clk(i_clk), .i_nrst(i_nrst), .i_busy(i_busy), .i_command(o_command),
	.i_blockValid(i_blockValid), .i_blockAdr(i_blockAdr),
	.i_blockMask(i_blockMask), .i_blockData(i_blockData),
	.i_adr(o_adr), .i_mask(o_writeMask), .i_data(o_dataOut)
);

/* tbChecker.sv */
module tbChecker (
	input  logic					i_clk,
	input  logic					i_nrst,
	input  logic					i_newTest,
	input  int						i_testNum,
	input  int						i_expPix,
	input  int						i_expCmds,
	input  renderPkg::coord_t		i_rectX,
	input  renderPkg::coord_t		i_rectY,
	input  logic [10:0]				i_rectW,
	input  logic [10:0]				i_rectH,
	input  renderPkg::colour_t		i_colour,
	input  renderPkg::areaCoord_t	i_areaX0,
	input  renderPkg::areaCoord_t	i_areaY0,
	input  renderPkg::areaCoord_t	i_areaX1,
	input  renderPkg::areaCoord_t	i_areaY1,
	input  logic					i_command,
	input  logic					i_memBusy,
	input  renderPkg::blockAdr_t	i_adr,
	input  renderPkg::blockMask_t	i_mask,
	input  renderPkg::blockData_t	i_data,
	input  logic					i_busy,
	input  logic					i_done,
	output int						o_passCount,
	output int						o_failCount,
	output int						o_errors
);

	timeunit 1ns;
	timeprecision 1ps;

	logic active, emptyRect, startQ, busyQ;
	int curTest, testErrors, cmdCount;
	int winL, winR, winT, winB, pixCalc, blocksCalc;
	renderPkg::colour_t expColour;
	// Pixels already written keyed by row * 1024 + x
	bit seen[int];

	task automatic flagError(input string msg);
		$display("[FAIL] %0t ns test %0d: %s", $time, curTest, msg);
		testErrors++;
		o_errors++;
	endtask

	// ----------------------------------------------------------
	// Expected window from the pixel rule
	// ----------------------------------------------------------
	task automatic openTest();
		int rx, ry, rr, rb;
		rx = int'(i_rectX);
		ry = int'(i_rectY);
		rr = rx + int'(i_rectW) - 1;
		rb = ry + int'(i_rectH) - 1;
		curTest = i_testNum;
		expColour = i_colour;
		winL = (rx > int'(i_areaX0)) ? rx : int'(i_areaX0);
		winT = (ry > int'(i_areaY0)) ? ry : int'(i_areaY0);
		winR = (rr < int'(i_areaX1)) ? rr : int'(i_areaX1);
		winB = (rb < int'(i_areaY1)) ? rb : int'(i_areaY1);
		emptyRect = (i_rectW == 0) || (i_rectH == 0) || (winL > winR) || (winT > winB);
		pixCalc = emptyRect ? 0 : (winR - winL + 1) * (winB - winT + 1);
		// One command per row and 16 pixel block touched
		blocksCalc = emptyRect ? 0 : (winR / 16 - winL / 16 + 1) * (winB - winT + 1);
		testErrors = 0;
		cmdCount = 0;
		seen.delete();
		active = 1'b1;
	endtask

	// Unpack every masked pixel of an accepted command
	task automatic checkWrite();
		int x, y, key;
		y = int'(i_adr[14:6]);
		cmdCount++;
		if (i_mask == '0)
			flagError($sformatf("command to block %0h with an empty mask", i_adr));
		for (int i = 0; i < renderPkg::BLOCK_PIXELS; i++) begin
			if (i_mask[i]) begin
				x = 16 * int'(i_adr[5:0]) + i;
				key = y * 1024 + x;
				if (emptyRect || x < winL || x > winR || y < winT || y > winB)
					flagError($sformatf("pixel (%0d,%0d) is outside the clipped area", x, y));
				if (i_data[i*16 +: 16] != expColour)
					flagError($sformatf("pixel (%0d,%0d) has colour %h, expected %h",
						x, y, i_data[i*16 +: 16], expColour));
				if (seen.exists(key))
					flagError($sformatf("pixel (%0d,%0d) written twice", x, y));
				seen[key] = 1'b1;
			end
		end
	endtask

	task automatic closeTest();
		if (!active) begin
			flagError("done strobe with no fill running");
		end else begin
			if (i_command)
				flagError("done while a memory command is still pending");
			// Done comes in the cycle busy falls
			if (i_busy || !busyQ)
				flagError("done not in the cycle where busy falls");
			if (pixCalc != i_expPix)
				flagError($sformatf("pixel rule gives %0d pixels, test file says %0d",
					pixCalc, i_expPix));
			if (blocksCalc != i_expCmds)
				flagError($sformatf("block count %0d differs from test file value %0d",
					blocksCalc, i_expCmds));
			if (seen.num() != pixCalc)
				flagError($sformatf("%0d pixels written, expected %0d", seen.num(), pixCalc));
			if (cmdCount != blocksCalc)
				flagError($sformatf("%0d commands, expected %0d", cmdCount, blocksCalc));
			if (testErrors == 0) begin
				o_passCount++;
				$display("test %0d passed: %0d pixels in %0d commands", curTest,
					seen.num(), cmdCount);
			end else begin
				o_failCount++;
				$display("[FAIL] %0t ns test %0d finished with %0d errors", $time, curTest,
					testErrors);
			end
			active = 1'b0;
		end
	endtask

	// ----------------------------------------------------------
	// Monitor
	// ----------------------------------------------------------
	always @(posedge i_clk) begin
		if (!i_nrst) begin
			active = 1'b0;
			startQ = 1'b0;
			busyQ = 1'b0;
			curTest = 0;
			o_passCount = 0;
			o_failCount = 0;
			o_errors = 0;
		end else begin
			// Quiet between fills
			if (!active && i_busy)
				flagError("busy high with no fill running");
			if (!active && i_command)
				flagError("memory command with no fill running");
			// Busy rises the cycle after start
			if (startQ && !i_busy)
				flagError("busy did not rise after start");
			if (i_newTest)
				openTest();
			// Acceptance is a command cycle with memory not busy
			if (i_command && !i_memBusy)
				checkWrite();
			if (i_done)
				closeTest();
			startQ = i_newTest;
			busyQ = i_busy;
		end
	end

endmodule

/* tb.sv */
module tb;

	timeunit 1ns;
	timeprecision 1ps;

	localparam string TEST_FILE = "render_tests.txt";
	localparam int SEED = 32'hdb99;
	localparam int MAX_TESTS = 32;
	localparam int RESET_CYCLES = 8;
	// Run budget for the timeout below
	localparam int CYCLES_PER_PIXEL = 40;
	localparam int CYCLES_PER_TEST = 200;

	logic clk, nrst, start, memBusy, newTest;
	renderPkg::coord_t rectX, rectY;
	logic [10:0] rectW, rectH;
	renderPkg::colour_t colour;
	renderPkg::areaCoord_t areaX0, areaY0, areaX1, areaY1;
	logic busy, done, command;
	renderPkg::blockAdr_t adr;
	renderPkg::blockMask_t writeMask;
	renderPkg::blockData_t dataOut;

	// One row per test line with the columns of the test file
	int tests[MAX_TESTS][12];
	int nTests, busyPct, testNum, expPix, expCmds, cycleLimit, cycles;
	int passCount, failCount, errorCount;

	renderTop UUT (
		.i_clk(clk), .i_nrst(nrst), .i_start(start),
		.i_rectX(rectX), .i_rectY(rectY), .i_rectW(rectW), .i_rectH(rectH),
		.i_colour(colour),
		.i_areaX0(areaX0), .i_areaY0(areaY0), .i_areaX1(areaX1), .i_areaY1(areaY1),
		.o_busy(busy), .o_done(done),
		.o_command(command), .i_busy(memBusy),
		.o_adr(adr), .o_writeMask(writeMask), .o_dataOut(dataOut)
	);

	tbChecker checkerInst (
		.i_clk(clk), .i_nrst(nrst), .i_newTest(newTest),
		.i_testNum(testNum), .i_expPix(expPix), .i_expCmds(expCmds),
		.i_rectX(rectX), .i_rectY(rectY), .i_rectW(rectW), .i_rectH(rectH),
		.i_colour(colour),
		.i_areaX0(areaX0), .i_areaY0(areaY0), .i_areaX1(areaX1), .i_areaY1(areaY1),
		.i_command(command), .i_memBusy(memBusy), .i_adr(adr), .i_mask(writeMask),
		.i_data(dataOut), .i_busy(busy), .i_done(done),
		.o_passCount(passCount), .o_failCount(failCount), .o_errors(errorCount)
	);

	// 8 ns clock
	always #4 clk = ~clk;

	// ----------------------------------------------------------
	// Memory busy model and run limit
	// ----------------------------------------------------------

	// Seeded once, then one draw per cycle
	initial begin
		memBusy = 1'b0;
		void'($urandom(SEED));
		forever begin
			@(posedge clk);
			if (!nrst)
				memBusy <= 1'b0;
			else
				memBusy <= ($urandom_range(99) < busyPct);
		end
	end

	always @(posedge clk) begin
		cycles <= cycles + 1;
		if (cycleLimit > 0 && cycles >= cycleLimit) begin
			$display("Timeout: the fills did not finish within %0d cycles", cycleLimit);
			finishRun(1'b1);
		end
	end

	task automatic finishRun(input bit failed);
		if (failed)
			$display("Result: FAILED");
		else
			$display("Result: PASSED");
		$finish;
	endtask

	// Lines starting with # are comments
	function automatic int readTests();
		int fd, n, count;
		string line;
		int v[12];
		count = 0;
		fd = $fopen(TEST_FILE, "r");
		if (fd == 0)
			return 0;
		while (!$feof(fd) && count < MAX_TESTS) begin
			line = "";
			void'($fgets(line, fd));
			if (line.len() > 1 && line[0] != "#") begin
				n = $sscanf(line, "%d %d %d %d %d %d %d %d %h %d %d %d", v[0], v[1], v[2],
					v[3], v[4], v[5], v[6], v[7], v[8], v[9], v[10], v[11]);
				if (n == 12) begin
					for (int i = 0; i < 12; i++)
						tests[count][i] = v[i];
					count++;
				end else begin
					$display("Skipping a test line that does not have 12 columns");
				end
			end
		end
		$fclose(fd);
		return count;
	endfunction

	// ----------------------------------------------------------
	// One fill loads the inputs, strobes start and waits for done
	// ----------------------------------------------------------
	task automatic runTest(input int t);
		@(posedge clk);
		areaX0 <= 10'(tests[t][0]);
		areaY0 <= 10'(tests[t][1]);
		areaX1 <= 10'(tests[t][2]);
		areaY1 <= 10'(tests[t][3]);
		// Negative origins truncate to 12 bit two's complement
		rectX <= 12'(tests[t][4]);
		rectY <= 12'(tests[t][5]);
		rectW <= 11'(tests[t][6]);
		rectH <= 11'(tests[t][7]);
		colour <= 16'(tests[t][8]);
		busyPct <= tests[t][9];
		expPix <= tests[t][10];
		expCmds <= tests[t][11];
		testNum <= t + 1;
		newTest <= 1'b1;
		start <= 1'b1;
		@(posedge clk);
		start <= 1'b0;
		newTest <= 1'b0;
		// Inputs stay put until done as colour is read per pixel
		@(posedge clk);
		while (!done)
			@(posedge clk);
	endtask

	initial begin
		clk = 1'b0;
		nrst = 1'b0;
		start = 1'b0;
		newTest = 1'b0;
		rectX = '0;
		rectY = '0;
		rectW = '0;
		rectH = '0;
		colour = '0;
		areaX0 = '0;
		areaY0 = '0;
		areaX1 = '0;
		areaY1 = '0;
		busyPct = 0;
		testNum = 0;
		expPix = 0;
		expCmds = 0;
		cycles = 0;
		cycleLimit = 0;
		nTests = readTests();
		if (nTests == 0) begin
			$display("No test could be read from %s", TEST_FILE);
			finishRun(1'b1);
		end else begin
			// Reset plus a fixed share per test and per expected pixel
			cycleLimit = RESET_CYCLES + 20;
			for (int t = 0; t < nTests; t++)
				cycleLimit += CYCLES_PER_PIXEL * tests[t][10] + CYCLES_PER_TEST;
			repeat (RESET_CYCLES) @(posedge clk);
			nrst <= 1'b1;
			for (int t = 0; t < nTests; t++)
				runTest(t);
			repeat (4) @(posedge clk);
			$display("Tests: %0d run, %0d passed, %0d failed, %0d errors, %0d assertion failures",
				nTests, passCount, failCount, errorCount,
				UUT.memWriterInst.renderChkInst.assertFails);
			finishRun(failCount != 0 || errorCount != 0 || passCount != nTests ||
				UUT.memWriterInst.renderChkInst.assertFails != 0);
		end
	end

endmodule

/* render_tests.txt */
# areaX0 areaY0 areaX1 areaY1 rectX rectY rectW rectH colour(hex) busy% expPixels expCommands
# Rectangle origin is signed, expected commands are distinct (row, 16 pixel block) pairs
0 0 639 479 16 8 32 4 7c1f 0 128 8
0 0 639 479 5 2 30 3 03e0 20 90 9
0 0 639 479 17 20 1 1 801f 0 1 1
0 0 639 479 -10 -3 20 6 001f 30 30 3
100 50 200 60 190 55 40 20 7fff 50 66 12
0 0 639 479 10 10 0 5 1234 0 0 0
0 0 639 479 10 10 5 0 1234 0 0 0
100 50 200 60 300 55 10 4 4321 20 0 0
0 0 639 479 -20 -20 10 10 5555 0 0 0
0 0 639 479 33 100 47 5 2a55 70 235 15
0 0 639 479 0 200 64 2 ffff 70 128 8
20 30 52 33 10 25 60 20 0c63 40 132 12
0 0 639 479 630 470 20 20 6318 10 100 10
0 0 639 479 48 300 1 3 0001 0 3 3

/* tb.f */
renderPkg.sv
rectClip.sv
rectScanner.sv
blockAssembler.sv
memWriter.sv
renderTop.sv
render_chk.sv
tbChecker.sv
tb.sv

/* Bender.yml */
package:
  name: rect_fill

sources:
  - renderPkg.sv
  - rectClip.sv
  - rectScanner.sv
  - blockAssembler.sv
  - memWriter.sv
  - renderTop.sv
  - target: simulation
    files:
      - render_chk.sv
      - tbChecker.sv
      - tb.sv
